/* tb.f */
src/icache_cfg_pkg.sv
src/icache_bus_pkg.sv
src/icache_way.sv
src/icache_plru.sv
src/icache_ctrl.sv
src/icache_top.sv
tb/icache_checker.sv
tb/icache_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= icache_tb
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "test FAILED"; exit 1; fi
	@grep -q "sim passed" $(LOG) || (echo "test FAILED, no result line"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/icache_tb.sv */
`timescale 1ns/1ps

module icache_tb;
    import icache_cfg_pkg::*;
    import icache_bus_pkg::*;

    localparam int N_ROWS = 22;
    localparam int LIMIT = N_ROWS * 60 + NUM_SETS + 16;

    typedef struct packed {
        logic [127:0] name;
        logic is_fence;
        logic [ADDR_W-1:0] addr;
        logic miss;
    } row_t;

    logic clk = 1'b0;
    logic rst;
    logic req_valid;
    logic [ADDR_W-1:0] req_addr;
    logic req_ready;
    logic resp_valid;
    line_t resp_line;
    logic ar_valid;
    mem_ar_t ar;
    logic ar_ready;
    logic r_valid;
    mem_r_t r;
    logic fence_req;
    logic fence_done;

    logic [127:0] cur_name;
    logic cur_miss;
    logic [31:0] rng;
    int errors;
    int checks;
    int resp_cnt = 0;
    int cycle_cnt = 0;

    // set 4 holds repl_a..repl_e, five lines for four ways
    row_t rows [N_ROWS] = '{
        '{"cold_a", 1'b0, 32'h0000_0100, 1'b1},
        '{"hit_a", 1'b0, 32'h0000_0108, 1'b0},
        '{"hit_a_b2b", 1'b0, 32'h0000_010c, 1'b0},
        '{"cold_b", 1'b0, 32'h0000_0200, 1'b1},
        '{"b2b_a", 1'b0, 32'h0000_0104, 1'b0},
        '{"b2b_b", 1'b0, 32'h0000_0204, 1'b0},
        '{"repl_a", 1'b0, 32'h0000_1040, 1'b1},
        '{"repl_b", 1'b0, 32'h0000_2040, 1'b1},
        '{"repl_c", 1'b0, 32'h0000_3040, 1'b1},
        '{"repl_d", 1'b0, 32'h0000_4040, 1'b1},
        '{"repl_e", 1'b0, 32'h0000_5048, 1'b1},
        '{"repl_b_hit", 1'b0, 32'h0000_2040, 1'b0},
        '{"repl_c_hit", 1'b0, 32'h0000_3044, 1'b0},
        '{"repl_d_hit", 1'b0, 32'h0000_4048, 1'b0},
        '{"repl_a_again", 1'b0, 32'h0000_1040, 1'b1},
        '{"fence", 1'b1, 32'h0000_0000, 1'b0},
        '{"fence_a", 1'b0, 32'h0000_0100, 1'b1},
        '{"fence_b", 1'b0, 32'h0000_0208, 1'b1},
        '{"fence_a_hit", 1'b0, 32'h0000_0104, 1'b0},
        '{"bp_0", 1'b0, 32'h0001_0300, 1'b1},
        '{"bp_1", 1'b0, 32'h0001_0314, 1'b1},
        '{"bp_0_hit", 1'b0, 32'h0001_030c, 1'b0}
    };

    always #4 clk = ~clk;

    icache_top #(.NUM_WAYS(4)) i_icache_top (.*);

    icache_checker i_checker (
        .clk(clk), .rst(rst), .req_valid(req_valid), .req_ready(req_ready),
        .req_addr(req_addr), .resp_valid(resp_valid), .resp_line(resp_line),
        .ar_valid(ar_valid), .ar_ready(ar_ready), .ar(ar),
        .fence_req(fence_req), .fence_done(fence_done),
        .test_name(cur_name), .exp_miss(cur_miss), .errors(errors), .checks(checks)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int rand_delay();
        rng = lcg_next(rng);
        return int'(rng[31:30]); // 0 to 3 cycles
    endfunction

    function automatic logic [31:0] mem_word(input logic [ADDR_W-1:0] addr);
        return addr ^ 32'hA5A5_0000;
    endfunction

    // one ar, then LINE_WORDS beats with random gaps
    task automatic serve_line();
        logic [ADDR_W-1:0] base;
        int gap;
        gap = rand_delay();
        repeat (gap) @(posedge clk);
        if (gap > 0) #1;
        ar_ready = 1'b1;
        base = ar.addr;
        @(posedge clk);
        #1;
        ar_ready = 1'b0;
        for (int w = 0; w < LINE_WORDS; w++) begin
            gap = rand_delay();
            repeat (gap) @(posedge clk);
            if (gap > 0) #1;
            r_valid = 1'b1;
            r.data = mem_word(base + ADDR_W'(4 * w));
            r.last = (w == LINE_WORDS - 1);
            @(posedge clk);
            #1;
            r_valid = 1'b0;
            r.last = 1'b0;
        end
    endtask

    task automatic wait_accept();
        @(negedge clk);
        while (!req_ready) @(negedge clk);
        @(posedge clk); // handshake edge
        #1;
    endtask

    task automatic wait_responses(input int n);
        while (resp_cnt < n) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic run_fence();
        fence_req = 1'b1;
        @(posedge clk);
        #1;
        fence_req = 1'b0;
        @(negedge clk);
        while (!fence_done) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    initial begin : mem_model
        rng = 32'h5cf40c8b;
        ar_ready = 1'b0;
        r_valid = 1'b0;
        r = '0;
        forever begin
            @(posedge clk);
            #1;
            if (!rst && ar_valid) serve_line();
        end
    end

    always @(posedge clk) begin : resp_count
        if (!rst && resp_valid) resp_cnt <= resp_cnt + 1;
    end

    always @(posedge clk) begin : watchdog
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= LIMIT) begin
            $display("timeout after %0d cycles, %0d responses seen", LIMIT, resp_cnt);
            $display("sim failed");
            $finish;
        end
    end

    initial begin : stimulus
        int issued;
        issued = 0;
        rst = 1'b1;
        req_valid = 1'b0;
        req_addr = '0;
        fence_req = 1'b0;
        cur_name = '0;
        cur_miss = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < N_ROWS; i++) begin
            if (rows[i].is_fence) begin
                req_valid = 1'b0;
                wait_responses(issued); // sweep starts from IDLE only
                cur_name = rows[i].name;
                run_fence();
            end else begin
                req_valid = 1'b1; // next fetch goes out right behind the last one
                req_addr = rows[i].addr;
                cur_name = rows[i].name;
                cur_miss = rows[i].miss;
                wait_accept();
                issued++;
            end
        end
        req_valid = 1'b0;
        wait_responses(issued);
        repeat (2) @(posedge clk);
        $display("checks %0d, errors %0d, responses %0d of %0d",
                 checks, errors, resp_cnt, issued);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* tb/icache_checker.sv */
`timescale 1ns/1ps

module icache_checker (
    input logic clk,
    input logic rst,
    input logic req_valid,
    input logic req_ready,
    input logic [icache_cfg_pkg::ADDR_W-1:0] req_addr,
    input logic resp_valid,
    input icache_cfg_pkg::line_t resp_line,
    input logic ar_valid,
    input logic ar_ready,
    input icache_bus_pkg::mem_ar_t ar,
    input logic fence_req,
    input logic fence_done,
    input logic [127:0] test_name,
    input logic exp_miss,
    output int errors,
    output int checks
);
    import icache_cfg_pkg::*;
    import icache_bus_pkg::*;

    // one accepted fetch waiting for its response
    typedef struct packed {
        logic [127:0] name;
        logic [ADDR_W-1:0] addr;
        logic miss;
        logic [31:0] cyc;
    } pend_t;

    pend_t pend_q [$];
    pend_t head;
    pend_t entry;
    logic [31:0] cyc = '0;
    logic [ADDR_W-1:0] line_addr;
    int ar_seen = 0;
    int err_cnt = 0;
    int chk_cnt = 0;
    logic fence_busy = 1'b0;
    int fence_wait = 0;
    logic [127:0] fence_name;

    assign errors = err_cnt;
    assign checks = chk_cnt;

    // memory returns A ^ 32'hA5A5_0000 for the word at byte address A
    function automatic line_t line_at(input logic [ADDR_W-1:0] addr);
        line_t l;
        logic [ADDR_W-1:0] base;
        base = {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        for (int w = 0; w < LINE_WORDS; w++) begin
            l[w] = (base + ADDR_W'(4 * w)) ^ 32'hA5A5_0000;
        end
        return l;
    endfunction

    task automatic check_field(input logic [127:0] name, input string what,
                               input logic [127:0] exp, input logic [127:0] act);
        chk_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("** Error %0s %0s: expected %h, actual %h", name, what, exp, act);
        end
    endtask

    always @(posedge clk) begin : watch
        if (!rst) begin
            cyc = cyc + 1;
            if (ar_valid && ar_ready) begin
                if (pend_q.size() == 0) begin
                    err_cnt++;
                    $display("memory read issued with no fetch outstanding");
                end else begin
                    ar_seen++;
                    line_addr = {pend_q[0].addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
                    check_field(pend_q[0].name, "ar addr", 128'(line_addr), 128'(ar.addr));
                    check_field(pend_q[0].name, "ar len", 128'(LINE_WORDS - 1), 128'(ar.len));
                end
            end
            if (resp_valid) begin
                if (pend_q.size() == 0) begin
                    err_cnt++;
                    $display("response seen with no fetch outstanding");
                end else begin
                    head = pend_q.pop_front();
                    check_field(head.name, "line", 128'(line_at(head.addr)), 128'(resp_line));
                    check_field(head.name, "ar count", 128'(head.miss), 128'(ar_seen));
                    if (!head.miss) begin
                        check_field(head.name, "hit latency", 128'(1), 128'(cyc - head.cyc));
                    end
                end
                ar_seen = 0;
                if (req_valid && !req_ready) begin
                    err_cnt++;
                    $display("fetch was held off in a response cycle");
                end
            end
            if (req_valid && req_ready) begin
                entry.name = test_name;
                entry.addr = req_addr;
                entry.miss = exp_miss;
                entry.cyc = cyc;
                pend_q.push_back(entry);
            end
            if (fence_busy) begin
                fence_wait++;
                if (fence_done) begin
                    // one cycle per set plus the done cycle
                    check_field(fence_name, "fence done cycle", 128'(NUM_SETS + 1),
                                128'(fence_wait));
                    fence_busy = 1'b0;
                end else if (req_ready) begin
                    err_cnt++;
                    $display("fetch was allowed during the fence sweep");
                end
            end else if (fence_done) begin
                err_cnt++;
                $display("fence done pulsed with no fence running");
            end
            if (fence_req && !fence_busy) begin
                fence_busy = 1'b1;
                fence_wait = 0;
                fence_name = test_name;
            end
        end
    end

endmodule

/* src/icache_top.sv */
`timescale 1ns/1ps

module icache_top #(
    parameter int NUM_WAYS = 4
) (
    input logic clk,
    input logic rst,
    input logic req_valid,
    input logic [icache_cfg_pkg::ADDR_W-1:0] req_addr,
    output logic req_ready,
    output logic resp_valid,
    output icache_cfg_pkg::line_t resp_line,
    output logic ar_valid,
    output icache_bus_pkg::mem_ar_t ar,
    input logic ar_ready,
    input logic r_valid,
    input icache_bus_pkg::mem_r_t r,
    input logic fence_req,
    output logic fence_done
);
    import icache_cfg_pkg::*;
    import icache_bus_pkg::*;

    localparam int WAY_W = $clog2(NUM_WAYS);

    index_t rd_index;
    tag_t lookup_tag;
    way_wr_t wr;
    logic [NUM_WAYS-1:0] wr_sel;
    logic [NUM_WAYS-1:0] way_hit;
    line_t way_line [NUM_WAYS];

    index_t plru_index;
    logic plru_touch;
    logic [WAY_W-1:0] plru_way;
    logic [WAY_W-1:0] victim_way;

    icache_ctrl #(
        .NUM_WAYS(NUM_WAYS)
    ) i_ctrl (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_addr(req_addr), .req_ready(req_ready),
        .resp_valid(resp_valid), .resp_line(resp_line),
        .ar_valid(ar_valid), .ar(ar), .ar_ready(ar_ready),
        .r_valid(r_valid), .r(r),
        .fence_req(fence_req), .fence_done(fence_done),
        .rd_index(rd_index), .lookup_tag(lookup_tag),
        .way_hit(way_hit), .way_line(way_line),
        .wr(wr), .wr_sel(wr_sel),
        .plru_index(plru_index), .plru_touch(plru_touch),
        .plru_way(plru_way), .victim_way(victim_way)
    );

    icache_plru #(
        .NUM_WAYS(NUM_WAYS)
    ) i_plru (
        .clk(clk), .rst(rst),
        .set_index(plru_index), .touch(plru_touch),
        .touch_way(plru_way), .victim_way(victim_way)
    );

    for (genvar i = 0; i < NUM_WAYS; i++) begin : g_way
        icache_way i_way (
            .clk(clk), .rst(rst),
            .rd_index(rd_index), .lookup_tag(lookup_tag),
            .wr(wr), .wr_sel(wr_sel[i]),
            .hit(way_hit[i]), .rd_line(way_line[i])
        );
    end

endmodule

/* src/icache_ctrl.sv */
`timescale 1ns/1ps

module icache_ctrl #(
    parameter int NUM_WAYS = 4
) (
    input logic clk,
    input logic rst,
    input logic req_valid,
    input logic [icache_cfg_pkg::ADDR_W-1:0] req_addr,
    output logic req_ready,
    output logic resp_valid,
    output icache_cfg_pkg::line_t resp_line,
    output logic ar_valid,
    output icache_bus_pkg::mem_ar_t ar,
    input logic ar_ready,
    input logic r_valid,
    input icache_bus_pkg::mem_r_t r,
    input logic fence_req,
    output logic fence_done,
    output icache_cfg_pkg::index_t rd_index,
    output icache_cfg_pkg::tag_t lookup_tag,
    input logic [NUM_WAYS-1:0] way_hit,
    input icache_cfg_pkg::line_t way_line [NUM_WAYS],
    output icache_bus_pkg::way_wr_t wr,
    output logic [NUM_WAYS-1:0] wr_sel,
    output icache_cfg_pkg::index_t plru_index,
    output logic plru_touch,
    output logic [$clog2(NUM_WAYS)-1:0] plru_way,
    input logic [$clog2(NUM_WAYS)-1:0] victim_way
);
    import icache_cfg_pkg::*;
    import icache_bus_pkg::*;

    localparam int WAY_W = $clog2(NUM_WAYS);
    localparam int BEAT_W = $clog2(LINE_WORDS);

    typedef enum logic [1:0] {IDLE, LOOKUP, MISS, REFILL} state_t;

    typedef struct packed {
        tag_t tag;
        index_t index;
    } req_buf_t;

    state_t state;
    req_buf_t req_q;
    logic run; // low only while in reset
    logic refill_resp;
    logic [WAY_W-1:0] miss_way;
    logic [BEAT_W-1:0] beat;
    line_t line_buf;
    line_t fill_line;
    logic fence_active;
    index_t fence_idx;

    logic accept, any_hit, lookup_hit, refill_en, fence_start;
    logic [WAY_W-1:0] hit_way;
    way_wr_t fill_wr, fence_wr;

    always_comb begin
        hit_way = '0;
        for (int i = 0; i < NUM_WAYS; i++) begin
            if (way_hit[i]) begin
                hit_way = WAY_W'(i);
            end
        end
    end

    assign any_hit = |way_hit;
    assign lookup_hit = (state == LOOKUP) && any_hit;
    assign refill_en = (state == REFILL) && r_valid && r.last;
    assign fence_start = (state == IDLE) && fence_req && !fence_active;

    // a hit in LOOKUP frees the pipe for the next fetch
    assign req_ready = run && (((state == IDLE) && !fence_active && !fence_req) || lookup_hit);
    assign accept = req_valid && req_ready;

    assign resp_valid = lookup_hit || refill_resp;
    assign resp_line = refill_resp ? line_buf : way_line[hit_way];

    // keep reads off the set being written
    assign rd_index = (|wr_sel) ? index_t'(wr.index + 1'b1) : req_addr[OFFSET_W +: INDEX_W];
    assign lookup_tag = req_q.tag;

    assign ar_valid = (state == MISS);
    assign ar.addr = {req_q.tag, req_q.index, {OFFSET_W{1'b0}}};
    assign ar.len = 8'(LINE_WORDS - 1);

    // last beat goes straight into the array along with the buffer
    always_comb begin
        fill_line = line_buf;
        fill_line[beat] = r.data;
    end

    assign fill_wr = '{index: req_q.index, tag: req_q.tag, valid: 1'b1,
                       line: fill_line, data_we: 1'b1};
    assign fence_wr = '{index: fence_idx, tag: '0, valid: 1'b0, line: '0, data_we: 1'b0};
    assign wr = fence_active ? fence_wr : fill_wr;
    assign wr_sel = fence_active ? '1 : (refill_en ? (NUM_WAYS'(1) << miss_way) : '0);

    assign plru_index = req_q.index;
    assign plru_touch = lookup_hit || refill_en;
    assign plru_way = refill_en ? miss_way : hit_way;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            run <= 1'b0;
            refill_resp <= 1'b0;
            miss_way <= '0;
            beat <= '0;
            fence_active <= 1'b0;
            fence_idx <= '0;
            fence_done <= 1'b0;
        end else begin
            run <= 1'b1;
            refill_resp <= refill_en;
            fence_done <= fence_active && (&fence_idx);
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (!any_hit) begin
                        state <= MISS;
                        miss_way <= victim_way;
                    end else if (!accept) begin
                        state <= IDLE;
                    end
                end
                MISS: begin
                    if (ar_ready) begin
                        state <= REFILL;
                        beat <= '0;
                    end
                end
                REFILL: begin
                    if (r_valid) begin
                        beat <= beat + 1'b1;
                        if (r.last) begin
                            state <= IDLE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
            // sweep one set per cycle, counter wraps back to 0
            if (fence_start) begin
                fence_active <= 1'b1;
            end else if (fence_active && (&fence_idx)) begin
                fence_active <= 1'b0;
            end
            if (fence_active) begin
                fence_idx <= fence_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q.tag <= req_addr[ADDR_W-1 -: TAG_W];
            req_q.index <= req_addr[OFFSET_W +: INDEX_W];
        end
        if ((state == REFILL) && r_valid) begin
            line_buf[beat] <= r.data;
        end
    end

    hit_onehot: assert property (
        @(posedge clk) disable iff (rst)
        (state == LOOKUP) |-> $onehot0(way_hit)
    );

    beat_in_refill: assert property (
        @(posedge clk) disable iff (rst)
        r_valid |-> (state == REFILL)
    );

endmodule

/* src/icache_plru.sv */
`timescale 1ns/1ps

module icache_plru #(
    parameter int NUM_WAYS = 4
) (
    input logic clk,
    input logic rst,
    input icache_cfg_pkg::index_t set_index,
    input logic touch,
    input logic [$clog2(NUM_WAYS)-1:0] touch_way,
    output logic [$clog2(NUM_WAYS)-1:0] victim_way
);
    import icache_cfg_pkg::*;

    localparam int LVL = $clog2(NUM_WAYS);

    // heap order, node 0 is the root; a bit set means go right
    logic [NUM_WAYS-2:0] tree_q [NUM_SETS];
    logic [NUM_WAYS-2:0] cur;
    logic [NUM_WAYS-2:0] nxt;

    assign cur = tree_q[set_index];

    always_comb begin
        int vnode;
        vnode = 0;
        victim_way = '0;
        for (int lvl = 0; lvl < LVL; lvl++) begin
            victim_way[LVL-1-lvl] = cur[vnode];
            vnode = 2 * vnode + 1 + int'(cur[vnode]);
        end
    end

    // point every node on the path away from the touched way
    always_comb begin
        int tnode;
        tnode = 0;
        nxt = cur;
        for (int lvl = 0; lvl < LVL; lvl++) begin
            nxt[tnode] = ~touch_way[LVL-1-lvl];
            tnode = 2 * tnode + 1 + int'(touch_way[LVL-1-lvl]);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                tree_q[s] <= '0;
            end
        end else if (touch) begin
            tree_q[set_index] <= nxt;
        end
    end

    // a touched way never comes straight back as the victim
    victim_not_touched: assert property (
        @(posedge clk) disable iff (rst)
        touch |=> (set_index != $past(set_index)) || (victim_way != $past(touch_way))
    );

endmodule

/* src/icache_way.sv */
`timescale 1ns/1ps

module icache_way (
    input logic clk,
    input logic rst,
    input icache_cfg_pkg::index_t rd_index,
    input icache_cfg_pkg::tag_t lookup_tag,
    input icache_bus_pkg::way_wr_t wr,
    input logic wr_sel,
    output logic hit,
    output icache_cfg_pkg::line_t rd_line
);
    import icache_cfg_pkg::*;

    tag_t tag_mem [NUM_SETS];
    line_t data_mem [NUM_SETS];
    logic [NUM_SETS-1:0] valid_q;

    tag_t rd_tag;
    logic rd_valid;

    // per-set valid bits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (wr_sel) begin
                valid_q[wr.index] <= wr.valid;
            end
            rd_valid <= valid_q[rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_sel) begin
            tag_mem[wr.index] <= wr.tag;
            if (wr.data_we) begin
                data_mem[wr.index] <= wr.line;
            end
        end
        rd_tag <= tag_mem[rd_index];
        rd_line <= data_mem[rd_index];
    end

    assign hit = rd_valid && (rd_tag == lookup_tag);

    // controller keeps the read port off the set under write
    wr_rd_apart: assert property (
        @(posedge clk) disable iff (rst)
        wr_sel |-> (wr.index != rd_index)
    );

endmodule

/* src/icache_bus_pkg.sv */
package icache_bus_pkg;

    // read address channel, a single handshake per line
    typedef struct packed {
        logic [icache_cfg_pkg::ADDR_W-1:0] addr; // line aligned
        logic [7:0] len; // beats minus one
    } mem_ar_t;

    // read data beat, no back-pressure
    typedef struct packed {
        logic [icache_cfg_pkg::WORD_W-1:0] data;
        logic last;
    } mem_r_t;

    // shared write port into the way arrays
    typedef struct packed {
        icache_cfg_pkg::index_t index;
        icache_cfg_pkg::tag_t tag;
        logic valid;
        icache_cfg_pkg::line_t line;
        logic data_we; // clear on fence invalidate
    } way_wr_t;

endpackage

/* src/icache_cfg_pkg.sv */
package icache_cfg_pkg;

    // fetch address and word geometry
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;

    // one line is four instruction words
    localparam int LINE_WORDS = 4;
    localparam int NUM_SETS = 64;

    // address split, tag | index | offset
    localparam int OFFSET_W = $clog2(LINE_WORDS * WORD_W / 8);
    localparam int INDEX_W = $clog2(NUM_SETS);
    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0] tag_t;

    // word 0 sits in the low bits
    typedef logic [LINE_WORDS-1:0][WORD_W-1:0] line_t;

endpackage
